// File: rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // datapath widths and memory depths
  localparam int data_width      = 32;
  localparam int inst_width      = 32;
  localparam int reg_addr_width  = 5;
  localparam int imem_addr_width = 8;
  localparam int dmem_addr_width = 8;

  // instruction field positions
  localparam int opcode_msb  = 31;
  localparam int opcode_lsb  = 26;
  localparam int rs_lsb      = 21;
  localparam int rt_lsb      = 16;
  localparam int rd_lsb      = 11;
  localparam int shamt_lsb   = 6;
  localparam int shamt_width = 5;
  localparam int imm_width   = 16;

  typedef enum logic [opcode_msb-opcode_lsb:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_slt  = 6'd5,
    op_sll  = 6'd6,
    op_addi = 6'd7,
    op_lw   = 6'd8,
    op_sw   = 6'd9,
    op_beq  = 6'd10,
    op_bne  = 6'd11,
    op_j    = 6'd12,
    op_jr   = 6'd13
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt,
    alu_sll
  } alu_op_e;

  typedef enum logic [1:0] {
    mem_none,
    mem_read,
    mem_write
  } mem_op_e;

  typedef enum logic [2:0] {
    jmp_none,
    jmp_beq,
    jmp_bne,
    jmp_target,
    jmp_reg
  } jump_op_e;

  typedef enum logic [1:0] {
    fwd_reg,
    fwd_ex_mem,
    fwd_mem_wb
  } fwd_sel_e;

  typedef struct packed {
    logic     reg_dst;
    logic     alu_src;
    logic     mem_to_reg;
    logic     reg_write;
    alu_op_e  alu_op;
    mem_op_e  mem_op;
    jump_op_e jop;
  } ctrl_t;

  typedef struct packed {
    logic                       valid;
    ctrl_t                      ctrl;
    logic [reg_addr_width-1:0]  rs;
    logic [reg_addr_width-1:0]  rt;
    logic [reg_addr_width-1:0]  rd;
    logic [shamt_width-1:0]     shamt;
    logic [imm_width-1:0]       immediate;
    logic [imem_addr_width-1:0] target;
    logic [data_width-1:0]      read_data_1;
    logic [data_width-1:0]      read_data_2;
  } id_ex_t;

  typedef struct packed {
    logic                      valid;
    logic                      reg_write;
    logic                      mem_to_reg;
    mem_op_e                   mem_op;
    logic [reg_addr_width-1:0] dest;
    logic [data_width-1:0]     alu_result;
    logic [data_width-1:0]     store_data;
  } ex_mem_t;

  typedef struct packed {
    logic                      valid;
    logic                      reg_write;
    logic                      mem_to_reg;
    logic [reg_addr_width-1:0] dest;
    logic [data_width-1:0]     alu_result;
    logic [data_width-1:0]     read_data;
  } mem_wb_t;

  typedef struct packed {
    logic                       enable;
    logic [imem_addr_width-1:0] address;
    logic [inst_width-1:0]      instruction;
  } imem_load_t;

  typedef struct packed {
    logic                      valid;
    logic [reg_addr_width-1:0] dest;
    logic [data_width-1:0]     data;
  } retire_t;

endpackage

`default_nettype wire

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  wire                                  clk,
  input  wire                                  reset,
  input  wire cpu_pkg::imem_load_t             imem_load,
  input  wire                                  stall,
  input  wire                                  redirect,
  input  wire [cpu_pkg::imem_addr_width-1:0]   redirect_pc,
  output logic [cpu_pkg::inst_width-1:0]       instruction,
  output logic                                 inst_valid
);

  logic [cpu_pkg::imem_addr_width-1:0] pc;
  logic [cpu_pkg::imem_addr_width-1:0] pc_next;
  logic [cpu_pkg::inst_width-1:0]      imem [0:(1 << cpu_pkg::imem_addr_width)-1];

  // program load port, one word per strobe
  always_ff @(posedge clk) begin
    if (imem_load.enable) begin
      imem[imem_load.address] <= imem_load.instruction;
    end
  end

  assign instruction = imem[pc];
  assign inst_valid  = !imem_load.enable;

  // redirect beats stall
  always_comb begin
    if (redirect) begin
      pc_next = redirect_pc;
    end else if (stall || imem_load.enable) begin
      pc_next = pc;
    end else begin
      pc_next = pc + cpu_pkg::imem_addr_width'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire                              clk,
  input  wire                              reset,
  input  wire [cpu_pkg::inst_width-1:0]    instruction,
  input  wire                              inst_valid,
  input  wire                              redirect,
  input  wire cpu_pkg::retire_t            retire,
  output logic                             stall,
  output cpu_pkg::id_ex_t                  id_ex
);

  cpu_pkg::opcode_e                     opcode;
  cpu_pkg::ctrl_t                       ctrl;
  cpu_pkg::id_ex_t                      id_ex_next;
  logic [cpu_pkg::reg_addr_width-1:0]   rs;
  logic [cpu_pkg::reg_addr_width-1:0]   rt;
  logic [cpu_pkg::reg_addr_width-1:0]   rd;
  logic [cpu_pkg::data_width-1:0]       read_data_1;
  logic [cpu_pkg::data_width-1:0]       read_data_2;
  logic [cpu_pkg::data_width-1:0]       regs [0:(1 << cpu_pkg::reg_addr_width)-1];

  assign opcode = cpu_pkg::opcode_e'(instruction[cpu_pkg::opcode_msb:cpu_pkg::opcode_lsb]);
  assign rs     = instruction[cpu_pkg::rs_lsb +: cpu_pkg::reg_addr_width];
  assign rt     = instruction[cpu_pkg::rt_lsb +: cpu_pkg::reg_addr_width];
  assign rd     = instruction[cpu_pkg::rd_lsb +: cpu_pkg::reg_addr_width];

  //////////////////////////////////////////////////////////////////////
  // control decode

  always_comb begin
    ctrl = '0;
    case (opcode)
      cpu_pkg::op_add,
      cpu_pkg::op_sub,
      cpu_pkg::op_and,
      cpu_pkg::op_or,
      cpu_pkg::op_slt,
      cpu_pkg::op_sll: begin
        ctrl.reg_dst   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      cpu_pkg::op_addi: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      cpu_pkg::op_lw: begin
        ctrl.alu_src    = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_op     = cpu_pkg::mem_read;
      end
      cpu_pkg::op_sw: begin
        ctrl.alu_src = 1'b1;
        ctrl.mem_op  = cpu_pkg::mem_write;
      end
      cpu_pkg::op_beq: ctrl.jop = cpu_pkg::jmp_beq;
      cpu_pkg::op_bne: ctrl.jop = cpu_pkg::jmp_bne;
      cpu_pkg::op_j:   ctrl.jop = cpu_pkg::jmp_target;
      cpu_pkg::op_jr:  ctrl.jop = cpu_pkg::jmp_reg;
      default: ;
    endcase

    // everything else adds, which also forms load/store addresses
    case (opcode)
      cpu_pkg::op_sub: ctrl.alu_op = cpu_pkg::alu_sub;
      cpu_pkg::op_and: ctrl.alu_op = cpu_pkg::alu_and;
      cpu_pkg::op_or:  ctrl.alu_op = cpu_pkg::alu_or;
      cpu_pkg::op_slt: ctrl.alu_op = cpu_pkg::alu_slt;
      cpu_pkg::op_sll: ctrl.alu_op = cpu_pkg::alu_sll;
      default:         ctrl.alu_op = cpu_pkg::alu_add;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // register file, write-back visible in the same cycle

  function automatic logic [cpu_pkg::data_width-1:0] read_reg(
    input logic [cpu_pkg::reg_addr_width-1:0] addr
  );
    if (addr == '0) begin
      return '0;
    end else if (retire.valid && retire.dest == addr) begin
      return retire.data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    read_data_1 = read_reg(rs);
    read_data_2 = read_reg(rt);
  end

  always_ff @(posedge clk) begin
    if (retire.valid) begin
      regs[retire.dest] <= retire.data;
    end
  end

  // load in EX feeding the instruction being decoded
  assign stall = id_ex.valid && id_ex.ctrl.mem_op == cpu_pkg::mem_read
              && id_ex.rt != '0 && (id_ex.rt == rs || id_ex.rt == rt);

  always_comb begin
    id_ex_next.valid       = inst_valid && !stall && !redirect;
    id_ex_next.ctrl        = ctrl;
    id_ex_next.rs          = rs;
    id_ex_next.rt          = rt;
    id_ex_next.rd          = rd;
    id_ex_next.shamt       = instruction[cpu_pkg::shamt_lsb +: cpu_pkg::shamt_width];
    id_ex_next.immediate   = instruction[cpu_pkg::imm_width-1:0];
    id_ex_next.target      = instruction[cpu_pkg::imem_addr_width-1:0];
    id_ex_next.read_data_1 = read_data_1;
    id_ex_next.read_data_2 = read_data_2;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex.valid <= 1'b0;
    end else begin
      id_ex <= id_ex_next;
    end
  end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  wire                                   clk,
  input  wire                                   reset,
  input  wire cpu_pkg::id_ex_t                  id_ex,
  input  wire cpu_pkg::retire_t                 retire,
  output cpu_pkg::ex_mem_t                      ex_mem,
  output logic                                  redirect,
  output logic [cpu_pkg::imem_addr_width-1:0]   redirect_pc
);

  cpu_pkg::fwd_sel_e               fwd_a;
  cpu_pkg::fwd_sel_e               fwd_b;
  cpu_pkg::ex_mem_t                ex_mem_next;
  logic [cpu_pkg::data_width-1:0]  operand_a;
  logic [cpu_pkg::data_width-1:0]  rt_value;
  logic [cpu_pkg::data_width-1:0]  operand_b;
  logic [cpu_pkg::data_width-1:0]  alu_result;
  logic                            equal;
  logic                            taken;

  //////////////////////////////////////////////////////////////////////
  // forwarding

  // the younger EX/MEM result wins; loads there are not ready yet
  function automatic cpu_pkg::fwd_sel_e fwd_select(
    input logic [cpu_pkg::reg_addr_width-1:0] src,
    input cpu_pkg::ex_mem_t                   ex_mem_q,
    input cpu_pkg::retire_t                   wb
  );
    if (ex_mem_q.valid && ex_mem_q.reg_write && ex_mem_q.mem_op != cpu_pkg::mem_read
        && ex_mem_q.dest != '0 && ex_mem_q.dest == src) begin
      return cpu_pkg::fwd_ex_mem;
    end else if (wb.valid && wb.dest == src) begin
      return cpu_pkg::fwd_mem_wb;
    end
    return cpu_pkg::fwd_reg;
  endfunction

  function automatic logic [cpu_pkg::data_width-1:0] pick_operand(
    input cpu_pkg::fwd_sel_e              sel,
    input logic [cpu_pkg::data_width-1:0] reg_value,
    input logic [cpu_pkg::data_width-1:0] ex_mem_value,
    input logic [cpu_pkg::data_width-1:0] wb_value
  );
    case (sel)
      cpu_pkg::fwd_ex_mem: return ex_mem_value;
      cpu_pkg::fwd_mem_wb: return wb_value;
      default:             return reg_value;
    endcase
  endfunction

  always_comb begin
    fwd_a     = fwd_select(id_ex.rs, ex_mem, retire);
    fwd_b     = fwd_select(id_ex.rt, ex_mem, retire);
    operand_a = pick_operand(fwd_a, id_ex.read_data_1, ex_mem.alu_result, retire.data);
    rt_value  = pick_operand(fwd_b, id_ex.read_data_2, ex_mem.alu_result, retire.data);
  end

  // immediate is zero-extended
  assign operand_b = id_ex.ctrl.alu_src
                   ? {{(cpu_pkg::data_width-cpu_pkg::imm_width){1'b0}}, id_ex.immediate}
                   : rt_value;

  //////////////////////////////////////////////////////////////////////
  // alu

  always_comb begin
    case (id_ex.ctrl.alu_op)
      cpu_pkg::alu_sub: alu_result = operand_a - operand_b;
      cpu_pkg::alu_and: alu_result = operand_a & operand_b;
      cpu_pkg::alu_or:  alu_result = operand_a | operand_b;
      cpu_pkg::alu_slt: begin
        alu_result = cpu_pkg::data_width'($signed(operand_a) < $signed(operand_b));
      end
      cpu_pkg::alu_sll: alu_result = operand_b << id_ex.shamt;
      default:          alu_result = operand_a + operand_b;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // branch and jump resolution

  assign equal = (operand_a == rt_value);

  always_comb begin
    case (id_ex.ctrl.jop)
      cpu_pkg::jmp_beq:    taken = equal;
      cpu_pkg::jmp_bne:    taken = !equal;
      cpu_pkg::jmp_target: taken = 1'b1;
      cpu_pkg::jmp_reg:    taken = 1'b1;
      default:             taken = 1'b0;
    endcase
  end

  assign redirect    = id_ex.valid && taken;
  assign redirect_pc = (id_ex.ctrl.jop == cpu_pkg::jmp_reg)
                     ? operand_a[cpu_pkg::imem_addr_width-1:0]
                     : id_ex.target;

  always_comb begin
    ex_mem_next.valid      = id_ex.valid;
    ex_mem_next.reg_write  = id_ex.ctrl.reg_write;
    ex_mem_next.mem_to_reg = id_ex.ctrl.mem_to_reg;
    ex_mem_next.mem_op     = id_ex.ctrl.mem_op;
    ex_mem_next.dest       = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;
    ex_mem_next.alu_result = alu_result;
    ex_mem_next.store_data = rt_value;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.valid <= 1'b0;
    end else begin
      ex_mem <= ex_mem_next;
    end
  end

endmodule

`default_nettype wire

// File: rtl/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
  input  wire                     clk,
  input  wire                     reset,
  input  wire cpu_pkg::ex_mem_t   ex_mem,
  output cpu_pkg::retire_t        retire
);

  cpu_pkg::mem_wb_t                     mem_wb;
  logic [cpu_pkg::dmem_addr_width-1:0]  dmem_addr;
  logic [cpu_pkg::data_width-1:0]       read_data;
  logic [cpu_pkg::data_width-1:0]       dmem [0:(1 << cpu_pkg::dmem_addr_width)-1];

  // word addressed, upper address bits ignored
  assign dmem_addr = ex_mem.alu_result[cpu_pkg::dmem_addr_width-1:0];

  always_ff @(posedge clk) begin
    if (ex_mem.valid && ex_mem.mem_op == cpu_pkg::mem_write) begin
      dmem[dmem_addr] <= ex_mem.store_data;
    end
  end

  assign read_data = (ex_mem.mem_op == cpu_pkg::mem_read) ? dmem[dmem_addr] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb.valid <= 1'b0;
    end else begin
      mem_wb.valid      <= ex_mem.valid;
      mem_wb.reg_write  <= ex_mem.reg_write;
      mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
      mem_wb.dest       <= ex_mem.dest;
      mem_wb.alu_result <= ex_mem.alu_result;
      mem_wb.read_data  <= read_data;
    end
  end

  // write-back select, r0 writes are dropped here
  always_comb begin
    retire.valid = mem_wb.valid && mem_wb.reg_write && mem_wb.dest != '0;
    retire.dest  = mem_wb.dest;
    retire.data  = mem_wb.mem_to_reg ? mem_wb.read_data : mem_wb.alu_result;
  end

endmodule

`default_nettype wire

// File: rtl/processor.sv
`timescale 1ns/1ps
`default_nettype none

module processor (
  input  wire                         clk,
  input  wire                         reset,
  input  wire cpu_pkg::imem_load_t    imem_load,
  output cpu_pkg::retire_t            retire
);

  logic [cpu_pkg::inst_width-1:0]       instruction;
  logic                                 inst_valid;
  logic                                 stall;
  logic                                 redirect;
  logic [cpu_pkg::imem_addr_width-1:0]  redirect_pc;
  cpu_pkg::id_ex_t                      id_ex;
  cpu_pkg::ex_mem_t                     ex_mem;

  //////////////////////////////////////////////////////////////////////
  // fetch and decode share a cycle

  fetch_unit fetch_inst (
    .clk         (clk),
    .reset       (reset),
    .imem_load   (imem_load),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .instruction (instruction),
    .inst_valid  (inst_valid)
  );

  decode_stage decode_inst (
    .clk         (clk),
    .reset       (reset),
    .instruction (instruction),
    .inst_valid  (inst_valid),
    .redirect    (redirect),
    .retire      (retire),
    .stall       (stall),
    .id_ex       (id_ex)
  );

  //////////////////////////////////////////////////////////////////////
  // execute, memory and write-back

  execute_stage execute_inst (
    .clk         (clk),
    .reset       (reset),
    .id_ex       (id_ex),
    .retire      (retire),
    .ex_mem      (ex_mem),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  memory_stage memory_inst (
    .clk    (clk),
    .reset  (reset),
    .ex_mem (ex_mem),
    .retire (retire)
  );

endmodule

`default_nettype wire

// File: tests/retire_checker.sv
`timescale 1ns/1ps
`default_nettype none

module retire_checker (
  input  wire                    clk,
  input  wire cpu_pkg::retire_t  retire,
  input  wire                    expect_push,
  input  wire cpu_pkg::retire_t  expect_entry,
  input  wire                    list_ready,
  output logic                   done,
  output int                     mismatch_count,
  output int                     missing_count,
  output int                     extra_count
);

  cpu_pkg::retire_t expected_q [$];

  // retire is sampled mid-cycle, away from the register updates
  always @(negedge clk) begin
    if (expect_push) begin
      expected_q.push_back(expect_entry);
    end
  end

  initial begin
    cpu_pkg::retire_t want;
    int               waited;
    int               index;
    logic             seen;
    done           = 1'b0;
    mismatch_count = 0;
    missing_count  = 0;
    extra_count    = 0;

    waited = 0;
    while (list_ready !== 1'b1 && waited < 5000) begin
      @(negedge clk);
      waited++;
    end
    if (list_ready !== 1'b1) begin
      $display("expected write-back list was never completed");
      missing_count++;
    end

    index = 0;
    while (index < expected_q.size()) begin
      want   = expected_q[index];
      seen   = 1'b0;
      waited = 0;
      while (!seen && waited < 500) begin
        @(negedge clk);
        if (retire.valid === 1'b1) begin
          seen = 1'b1;
        end else begin
          waited++;
        end
      end
      if (!seen) begin
        $display("no write-back for expected entry %0d within 500 cycles", index);
        missing_count += expected_q.size() - index;
        index = expected_q.size();
      end else begin
        if (retire.dest !== want.dest) begin
          $display("Fail retire.dest at entry %0d: got %h, expected %h",
                   index, retire.dest, want.dest);
          mismatch_count++;
        end
        if (retire.data !== want.data) begin
          $display("Fail retire.data at entry %0d: got %h, expected %h",
                   index, retire.data, want.data);
          mismatch_count++;
        end
        index++;
      end
    end

    // the closing self-jump writes nothing back
    waited = 0;
    while (waited < 100) begin
      @(negedge clk);
      if (retire.valid === 1'b1) begin
        $display("unexpected write-back to register %0d after the last expected one",
                 retire.dest);
        extra_count++;
      end
      waited++;
    end
    done = 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/tb_processor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_processor;

  typedef struct packed {
    logic [cpu_pkg::inst_width-1:0]     instruction;
    logic                               no_retire;
    logic [cpu_pkg::reg_addr_width-1:0] dest;
    logic [cpu_pkg::data_width-1:0]     data;
  } row_t;

  logic                           clk;
  logic                           reset;
  cpu_pkg::imem_load_t            imem_load;
  cpu_pkg::retire_t               retire;
  logic                           expect_push;
  cpu_pkg::retire_t               expect_entry;
  logic                           list_ready;
  logic                           check_done;
  int                             mismatch_count;
  int                             missing_count;
  int                             extra_count;
  row_t                           rows [$];
  logic [cpu_pkg::data_width-1:0] model_regs [0:(1 << cpu_pkg::reg_addr_width)-1];
  logic [cpu_pkg::data_width-1:0] model_mem [0:(1 << cpu_pkg::dmem_addr_width)-1];

  processor processor_inst (
    .clk       (clk),
    .reset     (reset),
    .imem_load (imem_load),
    .retire    (retire)
  );

  retire_checker retire_checker_inst (
    .clk            (clk),
    .retire         (retire),
    .expect_push    (expect_push),
    .expect_entry   (expect_entry),
    .list_ready     (list_ready),
    .done           (check_done),
    .mismatch_count (mismatch_count),
    .missing_count  (missing_count),
    .extra_count    (extra_count)
  );

  //////////////////////////////////////////////////////////////////////
  // instruction encoding and the sequential model

  function automatic logic [31:0] encode_r(cpu_pkg::opcode_e op, int rd, int rs, int rt,
                                           int shamt);
    return {op, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), 6'd0};
  endfunction

  function automatic logic [31:0] encode_i(cpu_pkg::opcode_e op, int rs, int rt,
                                           logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  // absolute address relative to the row being added
  function automatic logic [15:0] relative_addr(int offset);
    return 16'(rows.size() + offset);
  endfunction

  task automatic add_row(input logic [31:0] instruction, input logic no_retire,
                         input int dest, input logic [31:0] data);
    row_t row;
    row.instruction = instruction;
    row.no_retire   = no_retire;
    row.dest        = 5'(dest);
    row.data        = data;
    rows.push_back(row);
  endtask

  // r0 writes are dropped and retire nothing
  task automatic write_model(input logic [31:0] instruction, input int dest,
                             input logic [31:0] value);
    if (dest == 0) begin
      add_row(instruction, 1'b1, 0, '0);
    end else begin
      model_regs[dest] = value;
      add_row(instruction, 1'b0, dest, value);
    end
  endtask

  task automatic alu_row(input cpu_pkg::opcode_e op, input int rd, input int rs, input int rt,
                         input int shamt);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;
    a = model_regs[rs];
    b = model_regs[rt];
    case (op)
      cpu_pkg::op_add: result = a + b;
      cpu_pkg::op_sub: result = a - b;
      cpu_pkg::op_and: result = a & b;
      cpu_pkg::op_or:  result = a | b;
      cpu_pkg::op_slt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default:         result = b << shamt;
    endcase
    write_model(encode_r(op, rd, rs, rt, shamt), rd, result);
  endtask

  task automatic addi_row(input int rt, input int rs, input logic [15:0] imm);
    write_model(encode_i(cpu_pkg::op_addi, rs, rt, imm), rt, model_regs[rs] + {16'd0, imm});
  endtask

  task automatic store_row(input int rt, input int rs, input logic [15:0] imm);
    logic [7:0] addr;
    addr = 8'(model_regs[rs] + {16'd0, imm});
    model_mem[addr] = model_regs[rt];
    add_row(encode_i(cpu_pkg::op_sw, rs, rt, imm), 1'b1, 0, '0);
  endtask

  task automatic load_row(input int rt, input int rs, input logic [15:0] imm);
    logic [7:0] addr;
    addr = 8'(model_regs[rs] + {16'd0, imm});
    write_model(encode_i(cpu_pkg::op_lw, rs, rt, imm), rt, model_mem[addr]);
  endtask

  task automatic flow_row(input cpu_pkg::opcode_e op, input int rs, input int rt,
                          input logic [15:0] target);
    add_row(encode_i(op, rs, rt, target), 1'b1, 0, '0);
  endtask

  // sits behind a taken branch or jump, so the model skips it
  task automatic squashed_row(input logic [15:0] tag);
    add_row(encode_i(cpu_pkg::op_addi, 0, 20, tag), 1'b1, 0, '0);
  endtask

  task automatic build_program();
    logic [15:0] imm_a;
    logic [15:0] imm_b;
    logic [15:0] imm_c;
    logic [15:0] imm_d;
    logic [15:0] imm_e;
    int          shamt;
    imm_a = 16'($urandom());
    imm_b = 16'($urandom()) | 16'd1;
    imm_c = 16'($urandom());
    imm_d = 16'($urandom()) | 16'd1;
    imm_e = 16'($urandom());
    shamt = int'(5'($urandom()));
    // dependent arithmetic chain
    addi_row(1, 0, imm_a);
    addi_row(2, 1, imm_b);
    alu_row(cpu_pkg::op_add, 3, 1, 2, 0);
    alu_row(cpu_pkg::op_sub, 4, 3, 1, 0);
    alu_row(cpu_pkg::op_and, 5, 4, 3, 0);
    alu_row(cpu_pkg::op_or, 6, 5, 2, 0);
    alu_row(cpu_pkg::op_sub, 7, 1, 2, 0);
    alu_row(cpu_pkg::op_slt, 8, 7, 1, 0);
    alu_row(cpu_pkg::op_slt, 9, 1, 7, 0);
    alu_row(cpu_pkg::op_sll, 10, 0, 6, shamt);
    addi_row(11, 10, imm_c);
    // store, load back, then load-use
    addi_row(12, 0, 16'd16);
    store_row(11, 12, 16'd4);
    load_row(13, 12, 16'd4);
    alu_row(cpu_pkg::op_add, 14, 13, 1, 0);
    // branches and jumps
    flow_row(cpu_pkg::op_beq, 13, 11, relative_addr(2));
    squashed_row(16'd1);
    flow_row(cpu_pkg::op_bne, 1, 1, relative_addr(2));
    addi_row(16, 0, imm_d);
    flow_row(cpu_pkg::op_bne, 16, 0, relative_addr(2));
    squashed_row(16'd2);
    flow_row(cpu_pkg::op_j, 0, 0, relative_addr(2));
    squashed_row(16'd3);
    addi_row(17, 0, relative_addr(3));
    flow_row(cpu_pkg::op_jr, 17, 0, 16'd0);
    squashed_row(16'd4);
    // r0 stays zero
    addi_row(0, 1, imm_e);
    alu_row(cpu_pkg::op_add, 18, 0, 2, 0);
    flow_row(cpu_pkg::op_j, 0, 0, relative_addr(0));
    add_row(encode_i(cpu_pkg::op_nop, 0, 0, 16'd0), 1'b1, 0, '0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // clock, program load and final report

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    int waited;
    reset        <= 1'b1;
    imem_load    <= '0;
    expect_push  <= 1'b0;
    expect_entry <= '0;
    list_ready   <= 1'b0;
    void'($urandom(52919));
    for (int r = 0; r < (1 << cpu_pkg::reg_addr_width); r++) begin
      model_regs[r] = '0;
    end
    build_program();

    repeat (10) @(posedge clk);
    reset <= 1'b0;
    // the pc holds while the load strobe is high
    foreach (rows[i]) begin
      imem_load.enable      <= 1'b1;
      imem_load.address     <= cpu_pkg::imem_addr_width'(i);
      imem_load.instruction <= rows[i].instruction;
      expect_push           <= !rows[i].no_retire;
      expect_entry          <= {1'b1, rows[i].dest, rows[i].data};
      @(posedge clk);
    end
    imem_load.enable <= 1'b0;
    expect_push      <= 1'b0;
    list_ready       <= 1'b1;

    waited = 0;
    while (!check_done && waited < 5000) begin
      @(posedge clk);
      waited++;
    end
    if (!check_done) begin
      $display("retire checker did not finish within 5000 cycles");
    end
    $display("errors: mismatch %0d, missing %0d, extra %0d",
             mismatch_count, missing_count, extra_count);
    if (check_done && mismatch_count + missing_count + extra_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
rtl/cpu_pkg.sv
rtl/fetch_unit.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/processor.sv
tests/retire_checker.sv
tests/tb_processor.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_processor
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
